// File: verilog.f
+incdir+hw
hw/uart_pkg.sv
hw/spi_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/spi_master.sv
hw/slm_command_ctrl.sv
hw/readback_fifo.sv
hw/slm_bridge_top.sv
testbench/slm_bridge_props.sv
testbench/tb_slm_bridge.sv

// File: testbench/slm_bridge_testdata.txt
// Columns: address byte, data byte, SLM response byte (hex)
// Last line goes out with an idle gap between its two bytes
01 a5 3c
12 5a c3
7f 00 ff
80 ff 00
c4 96 69
3e e1 5b

// File: testbench/tb_slm_bridge.sv
/*
  Testbench for the SLM command bridge
  Clock, reset, UART driver and receiver, SLM SPI slave model, checks
*/
`include "bridge_params.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_slm_bridge;

  localparam int CPB        = `BRIDGE_CLKS_PER_BIT;
  localparam int NUM_FRAMES = 6;
  // Wait limits in sys_clk cycles
  localparam int CS_LIMIT    = 30 * CPB;
  localparam int FRAME_LIMIT = 40 * `BRIDGE_SPI_HALF_CLKS + 20;
  localparam int TX_LIMIT    = 4 * CPB;

  logic        sys_clk;
  logic        reset_all_cmd_w;
  logic        i_uart_rx;
  logic        i_spi_miso;
  logic        o_uart_tx;
  logic        o_spi_cs_n;
  logic        o_spi_sck;
  logic        o_spi_mosi;
  logic        o_slm_reset_n;
  logic [7:0]  test_mem [0:3*NUM_FRAMES-1];
  logic [15:0] frame_word;
  int          frame_rises;
  logic [7:0]  readback;
  int          hold_cycles;
  int          fails;

  slm_bridge_top dut0 (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_uart_rx       (i_uart_rx),
    .i_spi_miso      (i_spi_miso),
    .o_uart_tx       (o_uart_tx),
    .o_spi_cs_n      (o_spi_cs_n),
    .o_spi_sck       (o_spi_sck),
    .o_spi_mosi      (o_spi_mosi),
    .o_slm_reset_n   (o_slm_reset_n)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
    if (actual !== expected)
      stop_with_failure($sformatf("error %0t: %s is %h, expected %h",
                                  $time, what, actual, expected));
  endtask

  ////////////////////////////////////////
  // Host UART side
  ////////////////////////////////////////
  // 8N1, LSB first, one bit per CPB cycles
  task automatic send_byte(input logic [7:0] value);
    int bit_idx;
    i_uart_rx = 1'b0;
    repeat (CPB) @(negedge sys_clk);
    for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
      i_uart_rx = value[bit_idx];
      repeat (CPB) @(negedge sys_clk);
    end
    i_uart_rx = 1'b1;
    repeat (CPB) @(negedge sys_clk);
  endtask

  // Readback decode, sampled mid-bit
  task automatic receive_byte(output logic [7:0] value);
    int wait_cnt;
    int bit_idx;
    wait_cnt = 0;
    value = '0;
    while (o_uart_tx !== 1'b0) begin
      // No second frame while the readback is pending
      check_value(o_spi_cs_n, 1'b1, "chip select before readback");
      if (wait_cnt == TX_LIMIT)
        stop_with_failure("Timed out waiting for the readback start bit");
      wait_cnt++;
      @(negedge sys_clk);
    end
    repeat (CPB / 2) @(negedge sys_clk);
    check_value(o_uart_tx, 1'b0, "readback start bit");
    for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
      repeat (CPB) @(negedge sys_clk);
      value[bit_idx] = o_uart_tx;
    end
    repeat (CPB) @(negedge sys_clk);
    check_value(o_uart_tx, 1'b1, "readback stop bit");
  endtask

  // Fixed window with CS held high
  task automatic stay_idle(input int cycles);
    repeat (cycles) begin
      check_value(o_spi_cs_n, 1'b1, "chip select after a lone byte");
      @(negedge sys_clk);
    end
  endtask

  ////////////////////////////////////////
  // SLM slave model
  ////////////////////////////////////////
  // Response on the last 8 bits, MOSI recorded on rising SCK
  task automatic run_slave_frame(input logic [7:0] resp, output logic [15:0] mosi_bits,
                                 output int rises);
    int   wait_cnt;
    int   falls;
    logic sck_prev;
    mosi_bits = '0;
    rises = 0;
    falls = 0;
    sck_prev = 1'b0;
    wait_cnt = 0;
    i_spi_miso = 1'b0;
    while (o_spi_cs_n === 1'b1) begin
      if (wait_cnt == CS_LIMIT)
        stop_with_failure("Timed out waiting for the SPI frame to start");
      wait_cnt++;
      @(negedge sys_clk);
    end
    wait_cnt = 0;
    while (o_spi_cs_n === 1'b0) begin
      if (o_spi_sck && !sck_prev) begin
        rises++;
        mosi_bits = {mosi_bits[14:0], o_spi_mosi};
      end else if (!o_spi_sck && sck_prev) begin
        falls++;
        // Next rise index equals falls so far
        i_spi_miso = (falls >= 8 && falls <= 15) ? resp[15 - falls] : 1'b0;
      end
      sck_prev = o_spi_sck;
      if (wait_cnt == FRAME_LIMIT)
        stop_with_failure("Timed out waiting for the SPI frame to end");
      wait_cnt++;
      @(negedge sys_clk);
    end
    i_spi_miso = 1'b0;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    reset_all_cmd_w = 1'b1;
    i_uart_rx = 1'b1;
    i_spi_miso = 1'b0;
    $readmemh("testbench/slm_bridge_testdata.txt", test_mem);
    for (int i = 0; i < 3 * NUM_FRAMES; i++) begin
      if ((^test_mem[i]) === 1'bx)
        stop_with_failure("Test data file is missing or too short");
    end

    // Reset state, four rising edges with reset high
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    check_value(o_spi_cs_n, 1'b1, "chip select in reset");
    check_value(o_uart_tx, 1'b1, "UART line in reset");
    check_value(o_slm_reset_n, 1'b0, "SLM reset in reset");
    reset_all_cmd_w = 1'b0;

    // SLM reset stretch
    hold_cycles = 0;
    while (o_slm_reset_n !== 1'b1) begin
      if (hold_cycles == `BRIDGE_RESET_HOLD + 2)
        stop_with_failure("SLM reset stayed low too long after board reset");
      hold_cycles++;
      @(negedge sys_clk);
    end
    if (hold_cycles < `BRIDGE_RESET_HOLD)
      stop_with_failure("SLM reset released too early after board reset");

    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (f == NUM_FRAMES - 1) begin
        // Lone byte, then its partner after a gap
        fork
          send_byte(test_mem[3*f]);
          stay_idle(12 * CPB);
        join
        fork
          send_byte(test_mem[3*f+1]);
          run_slave_frame(test_mem[3*f+2], frame_word, frame_rises);
        join
      end else begin
        fork
          begin
            send_byte(test_mem[3*f]);
            send_byte(test_mem[3*f+1]);
          end
          run_slave_frame(test_mem[3*f+2], frame_word, frame_rises);
        join
      end
      check_value(16'(frame_rises), 16, "rising SCK edges in frame");
      check_value(frame_word, {test_mem[3*f], test_mem[3*f+1]}, "MOSI frame");
      receive_byte(readback);
      check_value(readback, test_mem[3*f+2], "readback byte");
    end

    fails = dut0.bridge_props.assert_fails;
    if (fails == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d assertion failures", fails));
    end
  end

endmodule

`default_nettype wire

// File: testbench/slm_bridge_props.sv
/*
  Concurrent assertions on SPI framing and readback start timing
  Bound into the top level, watching spi_master and readback_fifo
*/
`timescale 1ns/1ps
`default_nettype none

module slm_bridge_props (
  input logic sys_clk,
  input logic reset_all_cmd_w,
  input logic i_cs_n,
  input logic i_sck,
  input logic i_busy,
  input logic i_pop,
  input logic i_tx_start
);

  // Count of failed checks
  int assert_fails = 0;

  // SCK parked low outside a frame
  sck_idle_low: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    i_cs_n |-> !i_sck)
    else begin
      assert_fails++;
      $error("SCK high while chip select is inactive");
    end

  // Busy and CS move together
  busy_tracks_cs: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    i_busy == !i_cs_n)
    else begin
      assert_fails++;
      $error("busy does not match chip select");
    end

  // Pop then transmit start, one cycle apart
  start_after_pop: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    i_pop |=> i_tx_start)
    else begin
      assert_fails++;
      $error("no transmit start one cycle after a pop");
    end

  start_needs_pop: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    i_tx_start |-> $past(i_pop))
    else begin
      assert_fails++;
      $error("transmit start without a pop in the previous cycle");
    end

endmodule

////////////////////////////////////////
// One instance sees the SPI master and the FIFO together
bind slm_bridge_top slm_bridge_props bridge_props (
  .sys_clk         (sys_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .i_cs_n          (o_spi_cs_n),
  .i_sck           (o_spi_sck),
  .i_busy          (spi_cmd.busy),
  .i_pop           (u_fifo.pop),
  .i_tx_start      (tx_start)
);

`default_nettype wire

// File: hw/slm_bridge_top.sv
/*
  Host-to-SLM command bridge top level
  UART in, SPI out, readback FIFO back to UART
*/
`timescale 1ns/1ps
`default_nettype none

module slm_bridge_top (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic i_uart_rx,
  input  logic i_spi_miso,
  output logic o_uart_tx,
  output logic o_spi_cs_n,
  output logic o_spi_sck,
  output logic o_spi_mosi,
  output logic o_slm_reset_n
);

  logic                 rx_valid;
  uart_pkg::uart_byte_t rx_byte;
  logic                 tx_start;
  uart_pkg::uart_byte_t tx_byte;
  logic                 tx_active;

  spi_cmd_if spi_cmd ();

  ////////////////////////////////////////
  // Command path
  ////////////////////////////////////////
  uart_rx u_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_rx_serial     (i_uart_rx),
    .o_rx_valid      (rx_valid),
    .o_rx_byte       (rx_byte)
  );

  slm_command_ctrl u_ctrl (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_rx_valid      (rx_valid),
    .i_rx_byte       (rx_byte),
    .cmd             (spi_cmd.ctrl),
    .o_slm_reset_n   (o_slm_reset_n)
  );

  spi_master u_spi (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_spi_miso      (i_spi_miso),
    .cmd             (spi_cmd.master),
    .o_spi_cs_n      (o_spi_cs_n),
    .o_spi_sck       (o_spi_sck),
    .o_spi_mosi      (o_spi_mosi)
  );

  ////////////////////////////////////////
  // Readback path
  ////////////////////////////////////////
  readback_fifo u_fifo (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_tx_active     (tx_active),
    .spi             (spi_cmd.monitor),
    .o_tx_start      (tx_start),
    .o_tx_byte       (tx_byte)
  );

  uart_tx u_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .i_tx_start      (tx_start),
    .i_tx_byte       (tx_byte),
    .o_tx_active     (tx_active),
    .o_tx_serial     (o_uart_tx)
  );

endmodule

`default_nettype wire

// File: hw/readback_fifo.sv
/*
  Readback FIFO between SPI and UART transmitter
  Write on end of frame, drain one byte per idle transmitter
*/
`include "bridge_params.svh"
`timescale 1ns/1ps
`default_nettype none

module readback_fifo (
  input  logic                 sys_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 i_tx_active,
  spi_cmd_if.monitor           spi,
  output logic                 o_tx_start,
  output uart_pkg::uart_byte_t o_tx_byte
);

  localparam int DEPTH = `BRIDGE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

  uart_pkg::uart_byte_t mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W:0]       count;
  logic                 busy_d;
  logic                 full;
  logic                 empty;
  logic                 push;
  logic                 pop;

  assign full  = (count == FULL_CNT);
  assign empty = (count == '0);
  // Falling busy marks a finished frame, dropped when full
  assign push  = busy_d & ~spi.busy & ~full;
  // Start strobe still pending counts as busy transmitter
  assign pop   = ~empty & ~i_tx_active & ~o_tx_start;

  ////////////////////////////////////////
  // Pointers, count, start strobe
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      busy_d     <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_tx_start <= 1'b0;
    end else begin
      busy_d     <= spi.busy;
      o_tx_start <= pop;
      // Pointers wrap naturally, depth is a power of two
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and output byte
  always_ff @(posedge sys_clk) begin
    if (push)
      mem[wr_ptr] <= spi.rx_byte;
    if (pop)
      o_tx_byte <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

// File: hw/slm_command_ctrl.sv
/*
  Host byte pairing into SPI frames and SLM reset stretch
*/
`include "bridge_params.svh"
`timescale 1ns/1ps
`default_nettype none

module slm_command_ctrl (
  input  logic                 sys_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 i_rx_valid,
  input  uart_pkg::uart_byte_t i_rx_byte,
  spi_cmd_if.ctrl              cmd,
  output logic                 o_slm_reset_n
);

  localparam int HOLD_W = $clog2(`BRIDGE_RESET_HOLD + 1);

  logic              second_byte;
  logic [HOLD_W-1:0] hold_cnt;

  // Toggle marks the data byte of a pair
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      second_byte <= 1'b0;
      cmd.start   <= 1'b0;
    end else begin
      cmd.start <= i_rx_valid & second_byte;
      if (i_rx_valid)
        second_byte <= ~second_byte;
    end
  end

  // Previous byte moves up to address, new byte is data
  always_ff @(posedge sys_clk) begin
    if (i_rx_valid) begin
      cmd.frame.fields.addr <= cmd.frame.fields.data;
      cmd.frame.fields.data <= i_rx_byte;
    end
  end

  // SLM reset held low while the countdown runs
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt      <= HOLD_W'(`BRIDGE_RESET_HOLD);
      o_slm_reset_n <= 1'b0;
    end else if (hold_cnt != '0) begin
      hold_cnt      <= hold_cnt - 1'b1;
      o_slm_reset_n <= 1'b0;
    end else begin
      o_slm_reset_n <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_master.sv
/*
  Command interface between controller, SPI master and readback FIFO
  16-bit SPI mode-0 master, MSB first, MISO low byte captured
*/
`include "bridge_params.svh"
`timescale 1ns/1ps
`default_nettype none

interface spi_cmd_if;
  logic                 start;    // One-cycle launch strobe
  spi_pkg::spi_frame_u  frame;    // Address then data
  logic                 busy;     // High while CS is low
  uart_pkg::uart_byte_t rx_byte;  // Last 8 MISO bits

  modport ctrl    (output start, output frame);
  modport master  (input start, input frame, output busy, output rx_byte);
  modport monitor (input busy, input rx_byte);
endinterface

module spi_master (
  input  logic      sys_clk,
  input  logic      reset_all_cmd_w,
  input  logic      i_spi_miso,
  spi_cmd_if.master cmd,
  output logic      o_spi_cs_n,
  output logic      o_spi_sck,
  output logic      o_spi_mosi
);

  localparam int HC_W = $clog2(`BRIDGE_SPI_HALF_CLKS + 1);
  localparam logic [HC_W-1:0] HALF_LAST = HC_W'(`BRIDGE_SPI_HALF_CLKS - 1);

  spi_pkg::spi_state_t state;
  logic [HC_W-1:0]     half_cnt;
  logic [3:0]          bit_cnt;
  logic [15:0]         shift_word;
  logic                half_done;
  logic                sck_rise;
  logic                sck_fall;

  // SCK toggles at the end of each half period
  assign half_done = (state == spi_pkg::SPI_SHIFT) && (half_cnt == HALF_LAST);
  assign sck_rise  = half_done && !o_spi_sck;
  assign sck_fall  = half_done && o_spi_sck;
  // MOSI parked low outside a frame
  assign o_spi_mosi = shift_word[15] & ~o_spi_cs_n;

  ////////////////////////////////////////
  // Frame control
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state      <= spi_pkg::SPI_IDLE;
      cmd.busy   <= 1'b0;
      o_spi_cs_n <= 1'b1;
      o_spi_sck  <= 1'b0;
      half_cnt   <= '0;
      bit_cnt    <= '0;
    end else begin
      case (state)
        spi_pkg::SPI_IDLE: begin
          half_cnt <= '0;
          bit_cnt  <= '0;
          // Start only seen here, so ignored while busy
          if (cmd.start) begin
            cmd.busy   <= 1'b1;
            o_spi_cs_n <= 1'b0;
            state      <= spi_pkg::SPI_SHIFT;
          end
        end
        spi_pkg::SPI_SHIFT: begin
          half_cnt <= half_done ? '0 : half_cnt + 1'b1;
          if (half_done)
            o_spi_sck <= ~o_spi_sck;
          // Period ends on falling SCK
          if (sck_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd15)
              state <= spi_pkg::SPI_FINISH;
          end
        end
        spi_pkg::SPI_FINISH: begin
          // SCK already back low
          cmd.busy   <= 1'b0;
          o_spi_cs_n <= 1'b1;
          state      <= spi_pkg::SPI_IDLE;
        end
        default: state <= spi_pkg::SPI_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Shift registers
  ////////////////////////////////////////
  // Load on launch, advance on falling SCK
  always_ff @(posedge sys_clk) begin
    if ((state == spi_pkg::SPI_IDLE) && cmd.start)
      shift_word <= cmd.frame.word;
    else if (sck_fall)
      shift_word <= {shift_word[14:0], 1'b0};
  end

  // MISO sampled on rising SCK, keeps the last 8
  always_ff @(posedge sys_clk) begin
    if (sck_rise)
      cmd.rx_byte <= {cmd.rx_byte[6:0], i_spi_miso};
  end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
/*
  UART transmitter, 8N1, LSB first
  Active flag covers start bit through end of stop bit
*/
`include "bridge_params.svh"
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                 sys_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 i_tx_start,
  input  uart_pkg::uart_byte_t i_tx_byte,
  output logic                 o_tx_active,
  output logic                 o_tx_serial
);

  localparam int CNT_W = $clog2(`BRIDGE_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`BRIDGE_CLKS_PER_BIT - 1);

  uart_pkg::uart_state_t state;
  logic [CNT_W-1:0]      clk_cnt;
  logic [2:0]            bit_idx;
  uart_pkg::uart_byte_t  tx_data;
  logic                  bit_done;

  assign bit_done = (clk_cnt == BIT_LAST);

  // Hold the character for the whole frame
  always_ff @(posedge sys_clk) begin
    if ((state == uart_pkg::UART_IDLE) && i_tx_start)
      tx_data <= i_tx_byte;
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state       <= uart_pkg::UART_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      o_tx_active <= 1'b0;
      o_tx_serial <= 1'b1;
    end else begin
      // Bit timer runs in every state but idle
      clk_cnt <= (bit_done || (state == uart_pkg::UART_IDLE)) ? '0 : clk_cnt + 1'b1;
      case (state)
        uart_pkg::UART_IDLE: begin
          o_tx_serial <= 1'b1;
          bit_idx     <= '0;
          if (i_tx_start) begin
            o_tx_active <= 1'b1;
            o_tx_serial <= 1'b0;
            state       <= uart_pkg::UART_START;
          end
        end
        uart_pkg::UART_START: begin
          if (bit_done) begin
            o_tx_serial <= tx_data[0];
            state       <= uart_pkg::UART_DATA;
          end
        end
        uart_pkg::UART_DATA: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              o_tx_serial <= 1'b1;
              state       <= uart_pkg::UART_STOP;
            end else begin
              o_tx_serial <= tx_data[bit_idx + 3'd1];
            end
          end
        end
        uart_pkg::UART_STOP: begin
          // Line already high, release after one bit
          if (bit_done) begin
            o_tx_active <= 1'b0;
            state       <= uart_pkg::UART_IDLE;
          end
        end
        default: state <= uart_pkg::UART_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
/*
  UART receiver, 8N1, LSB first
  Two-flop line sync, mid-bit sampling, one-cycle valid at the stop bit
*/
`include "bridge_params.svh"
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                 sys_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 i_rx_serial,
  output logic                 o_rx_valid,
  output uart_pkg::uart_byte_t o_rx_byte
);

  localparam int CNT_W = $clog2(`BRIDGE_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`BRIDGE_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`BRIDGE_CLKS_PER_BIT / 2 - 1);

  logic                  rx_meta;
  logic                  rx_sync;
  uart_pkg::uart_state_t state;
  logic [CNT_W-1:0]      clk_cnt;
  logic [2:0]            bit_idx;
  logic                  bit_done;

  // Full bit time elapsed, lands mid-bit once aligned
  assign bit_done = (clk_cnt == BIT_LAST);

  // Line idles high, sync flops reset to idle
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx_serial;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state      <= uart_pkg::UART_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0;
      case (state)
        uart_pkg::UART_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // Falling edge of start bit
          if (!rx_sync)
            state <= uart_pkg::UART_START;
        end
        uart_pkg::UART_START: begin
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            // Still low at mid-bit, else a glitch
            state   <= rx_sync ? uart_pkg::UART_IDLE : uart_pkg::UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_pkg::UART_DATA: begin
          clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= uart_pkg::UART_STOP;
          end
        end
        uart_pkg::UART_STOP: begin
          clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
          if (bit_done) begin
            // Mid stop bit, framing check
            o_rx_valid <= rx_sync;
            state      <= uart_pkg::UART_IDLE;
          end
        end
        default: state <= uart_pkg::UART_IDLE;
      endcase
    end
  end

  // Data bits shift in from the top, LSB arrives first
  always_ff @(posedge sys_clk) begin
    if ((state == uart_pkg::UART_DATA) && bit_done)
      o_rx_byte <= {rx_sync, o_rx_byte[7:1]};
  end

endmodule

`default_nettype wire

// File: hw/spi_pkg.sv
/*
  SPI command frame layout and SPI master state encoding
*/
`default_nettype none

package spi_pkg;
  // Same 16 bits seen as the shift word or as address plus data
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] addr;  // Goes out first
      logic [7:0] data;
    } fields;
  } spi_frame_u;

  // SPI master FSM
  typedef enum logic [1:0] {
    SPI_IDLE   = 2'd0,
    SPI_SHIFT  = 2'd1,
    SPI_FINISH = 2'd2
  } spi_state_t;
endpackage

`default_nettype wire

// File: hw/uart_pkg.sv
/*
  UART character type and line-state encoding
*/
`default_nettype none

package uart_pkg;
  // One character on the serial line
  typedef logic [7:0] uart_byte_t;
  // Line states, shared by receiver and transmitter
  typedef enum logic [1:0] {
    UART_IDLE  = 2'd0,
    UART_START = 2'd1,
    UART_DATA  = 2'd2,
    UART_STOP  = 2'd3
  } uart_state_t;
endpackage

`default_nettype wire

// File: hw/bridge_params.svh
/*
  Timing and depth constants for the SLM command bridge
*/
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH
`default_nettype none

// sys_clk cycles per UART bit
// Board build at 50 MHz and 115200 baud uses 434
`define BRIDGE_CLKS_PER_BIT 16
// sys_clk cycles per SCK half period
`define BRIDGE_SPI_HALF_CLKS 4
// SLM reset low time after board reset
`define BRIDGE_RESET_HOLD 10
// Readback entries, power of two
`define BRIDGE_FIFO_DEPTH 4

`default_nettype wire
`endif
